/* sim.f */
audio_pkg.sv
regs_pkg.sv
i2s_rx.sv
echo_delay.sv
ir_convolver.sv
mix_pdm_out.sv
cfg_regs.sv
audio_top.sv
tb_audio_top.sv

/* tb_audio_top.sv */
`timescale 1ns/1ps

module tb_audio_top
  import audio_pkg::*;
  import regs_pkg::*;
;

  localparam int TIMEOUT_CYCLES = 20000;  // about 46 frames of tests plus margin
  localparam int PDM_WINDOW     = 1024;

  logic     audio_clk = 1'b0;
  logic     rst_n;
  logic     mic_data = 1'b0;
  apb_req_t apb_req;
  apb_rsp_t apb_rsp;
  logic     bclk;
  logic     lrcl;
  logic     pdm_out;

  // mic model state
  integer                    seed = 13640;
  logic signed [15:0]        pending [$];  // words queued by the tests
  logic signed [15:0]        sent [$];     // every word sent, oldest first
  logic signed [15:0]        cur_word = '0;
  logic                      bclk_prev = 1'b0;
  logic                      lrcl_prev = 1'b0;
  int                        bit_pos = 0;
  int                        frames_done = 0;

  // expected configuration
  logic signed [15:0]        tap_val [NUM_TAPS];
  int                        cur_delay;
  logic [7:0]                cur_echo_gain;
  logic [7:0]                cur_conv_gain;

  // checker controls
  logic        rd_chk = 1'b0;
  logic        acc_chk = 1'b0;
  logic        idle_chk = 1'b0;
  logic        dens_chk = 1'b0;
  logic [31:0] rd_exp;
  logic        err_exp;
  int          ones_cnt;
  int          dens_exp;
  int          err_cnt = 0;
  int          pass_cnt = 0;
  int          fail_cnt = 0;
  int          cycles = 0;
  int          errs;

  audio_top dut_i (
    .audio_clk (audio_clk),
    .rst_n     (rst_n),
    .mic_data  (mic_data),
    .apb_req   (apb_req),
    .bclk      (bclk),
    .lrcl      (lrcl),
    .pdm_out   (pdm_out),
    .apb_rsp   (apb_rsp)
  );

  always #50 audio_clk = ~audio_clk;

  // i2s mic, one delay bit then msb first in the left slot
  always @(negedge audio_clk) begin
    if (rst_n && bclk_prev && !bclk) begin
      if (lrcl_prev && !lrcl) bit_pos = 0;
      else bit_pos = bit_pos + 1;
      if (!lrcl && bit_pos == 1) begin
        cur_word = (pending.size() != 0) ? pending.pop_front() : 16'($random(seed));
        sent.push_back(cur_word);
      end
      if (!lrcl && bit_pos == 24) frames_done++;  // sample fully mixed by now
      mic_data = (!lrcl && bit_pos >= 1 && bit_pos <= 16) ? cur_word[16 - bit_pos] : 1'b0;
    end
    bclk_prev = bclk;
    lrcl_prev = lrcl;
  end

  always @(posedge audio_clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, tests did not finish", cycles);
      $display("Simulation FAILED");
      $finish;
    end
  end

  a_reset_idle: assert property (@(posedge audio_clk)
    idle_chk |-> !bclk && !lrcl && !pdm_out && !apb_rsp.pslverr && !apb_rsp.pready)
    else begin
      err_cnt++;
      $display("outputs not at their reset values while reset is held");
    end

  a_read_data: assert property (@(posedge audio_clk) disable iff (!rst_n)
    rd_chk |-> apb_rsp.prdata == rd_exp)
    else begin
      err_cnt++;
      $display("MISMATCH prdata expected %h actual %h", rd_exp, $sampled(apb_rsp.prdata));
    end

  a_slverr: assert property (@(posedge audio_clk) disable iff (!rst_n)
    acc_chk |-> apb_rsp.pslverr == err_exp)
    else begin
      err_cnt++;
      $display("MISMATCH pslverr expected %h actual %h", err_exp, $sampled(apb_rsp.pslverr));
    end

  a_ready: assert property (@(posedge audio_clk) disable iff (!rst_n)
    acc_chk |-> apb_rsp.pready)
    else begin
      err_cnt++;
      $display("pready was low in an apb access phase");
    end

  a_pdm_density: assert property (@(posedge audio_clk) disable iff (!rst_n)
    dens_chk |-> ones_cnt >= dens_exp - 4 && ones_cnt <= dens_exp + 4)
    else begin
      err_cnt++;
      $display("MISMATCH pdm_out ones expected %h actual %h", dens_exp, ones_cnt);
    end

  function automatic logic signed [15:0] clamp16(input longint v);
    if (v > 32767) return 16'sh7fff;
    if (v < -32768) return 16'sh8000;
    return 16'(v);
  endfunction

  // tap k times the word k frames back, Q1.15
  function automatic logic signed [15:0] conv_model();
    longint acc;
    longint x;
    acc = 0;
    for (int k = 0; k < NUM_TAPS; k++) begin
      x = (sent.size() > k) ? longint'(sent[sent.size() - 1 - k]) : 0;
      acc += longint'(tap_val[k]) * x;
    end
    return clamp16(acc >>> 15);
  endfunction

  function automatic logic signed [15:0] mix_model(input logic signed [15:0] echo,
                                                   input logic signed [15:0] conv);
    longint sum;
    sum = longint'(echo) * longint'(cur_echo_gain) + longint'(conv) * longint'(cur_conv_gain);
    return clamp16(sum >>> 7);
  endfunction

  // setup phase then access phase, idle after
  task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] data,
                          input logic chk_data, input logic bad);
    @(negedge audio_clk);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = wr;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wr ? data : 32'h0;
    @(negedge audio_clk);
    apb_req.penable = 1'b1;
    rd_exp  = data;
    rd_chk  = chk_data && !wr;
    err_exp = bad;
    acc_chk = 1'b1;
    @(negedge audio_clk);
    apb_req = '0;
    rd_chk  = 1'b0;
    acc_chk = 1'b0;
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data, input logic bad);
    apb_xfer(1'b1, addr, data, 1'b0, bad);
  endtask

  task automatic read_reg(input logic [7:0] addr, input logic [31:0] exp, input logic bad,
                          input logic chk_data);
    apb_xfer(1'b0, addr, exp, chk_data, bad);
  endtask

  task automatic write_tap(input int k, input logic signed [15:0] v);
    write_reg(8'(REG_TAP0 + 4 * k), {16'h0, v}, 1'b0);
    tap_val[k] = v;
  endtask

  task automatic read_taps();
    for (int k = 0; k < NUM_TAPS; k++) begin
      read_reg(8'(REG_TAP0 + 4 * k), {16'h0, tap_val[k]}, 1'b0, 1'b1);
    end
  endtask

  task automatic set_mix_cfg(input int delay, input logic [7:0] eg, input logic [7:0] cg);
    write_reg(REG_DELAY, 32'(delay), 1'b0);
    write_reg(REG_GAINS, {16'h0, cg, eg}, 1'b0);
    cur_delay     = delay;
    cur_echo_gain = eg;
    cur_conv_gain = cg;
  endtask

  task automatic wait_frames(input int n);
    int target;
    target = frames_done + n;
    while (frames_done < target) @(negedge audio_clk);
  endtask

  // echo from the sent record, zero before the first words
  task automatic check_mix();
    int                 n;
    logic signed [15:0] old;
    n   = sent.size();
    old = (n > cur_delay) ? sent[n - 1 - cur_delay] : 16'sd0;
    read_reg(REG_MIX, {16'h0, mix_model(old, conv_model())}, 1'b0, 1'b1);
  endtask

  task automatic pdm_density(input logic signed [15:0] x);
    int ones;
    wait_frames(1);
    pending.delete();
    repeat (7) pending.push_back(x);
    wait_frames(1);
    check_mix();
    ones = 0;
    repeat (PDM_WINDOW) begin
      @(negedge audio_clk);
      ones += pdm_out;
    end
    ones_cnt = ones;
    dens_exp = (PDM_WINDOW * (int'(x) + 32768)) / 65536;
    dens_chk = 1'b1;
    @(negedge audio_clk);
    dens_chk = 1'b0;
  endtask

  task automatic close_test(input string name, input int errs_before);
    if (err_cnt == errs_before) begin
      pass_cnt++;
      $display("test %s: ok", name);
    end else begin
      fail_cnt++;
      $display("test %s: %0d errors", name, err_cnt - errs_before);
    end
  endtask

  initial begin
    rst_n   = 1'b0;
    apb_req = '0;
    errs    = 0;
    repeat (6) @(negedge audio_clk);
    idle_chk = 1'b1;
    repeat (4) @(negedge audio_clk);
    idle_chk = 1'b0;
    rst_n    = 1'b1;

    read_reg(REG_DELAY, 32'h0, 1'b0, 1'b1);
    read_reg(REG_GAINS, 32'(GAIN_UNITY), 1'b0, 1'b1);
    for (int k = 0; k < NUM_TAPS; k++) write_tap(k, 16'($random(seed)));
    read_taps();
    write_reg(REG_GAINS, 32'h0000_a55a, 1'b0);
    read_reg(REG_GAINS, 32'h0000_a55a, 1'b0, 1'b1);
    read_reg(8'h40, 32'h0, 1'b1, 1'b0);
    write_reg(8'h40, 32'h0000_ffff, 1'b1);
    write_reg(REG_MIX, 32'h0000_1234, 1'b1);
    read_taps();  // bad writes left the taps alone
    close_test("reset and registers", errs);

    errs = err_cnt;
    wait_frames(1);
    set_mix_cfg(0, 8'h00, 8'(GAIN_UNITY));
    write_tap(0, 16'sh4000);
    for (int k = 1; k < NUM_TAPS; k++) write_tap(k, 16'sh0000);
    repeat (4) begin
      wait_frames(1);
      check_mix();
    end
    write_tap(1, 16'sh4000);
    repeat (4) begin
      wait_frames(1);
      check_mix();
    end
    close_test("convolver path", errs);

    errs = err_cnt;
    set_mix_cfg(5, 8'(GAIN_UNITY), 8'h00);
    repeat (20) begin
      wait_frames(1);
      check_mix();
    end
    close_test("echo path", errs);

    errs = err_cnt;
    set_mix_cfg(0, 8'hff, 8'hff);
    pending.delete();
    repeat (3) pending.push_back(16'sh7000);
    wait_frames(2);
    check_mix();  // clips high
    pending.delete();
    repeat (3) pending.push_back(-16'sh7000);
    wait_frames(2);
    check_mix();
    close_test("mix saturation", errs);

    errs = err_cnt;
    set_mix_cfg(0, 8'(GAIN_UNITY), 8'h00);
    pdm_density(16'sh2000);
    pdm_density(-16'sh4000);
    close_test("pdm density", errs);

    $display("tests passed %0d failed %0d, check errors %0d", pass_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0 && fail_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* audio_top.sv */
`timescale 1ns/1ps

module audio_top
  import audio_pkg::*;
  import regs_pkg::*;
(
  input  logic     audio_clk,
  input  logic     rst_n,
  input  logic     mic_data,
  input  apb_req_t apb_req,
  output logic     bclk,
  output logic     lrcl,
  output logic     pdm_out,
  output apb_rsp_t apb_rsp
);

  cfg_t    cfg;
  sample_t sample;
  sample_t echo;
  sample_t conv;
  sample_t mix_last;
  logic    sample_valid;
  logic    echo_valid;
  logic    conv_valid;

  i2s_rx u_i2s_rx (
    .audio_clk    (audio_clk),
    .rst_n        (rst_n),
    .mic_data     (mic_data),
    .bclk         (bclk),
    .lrcl         (lrcl),
    .sample       (sample),
    .sample_valid (sample_valid)
  );

  // both branches see every sample
  echo_delay u_echo_delay (
    .audio_clk    (audio_clk),
    .rst_n        (rst_n),
    .sample       (sample),
    .sample_valid (sample_valid),
    .cfg          (cfg),
    .echo         (echo),
    .echo_valid   (echo_valid)
  );

  ir_convolver u_ir_convolver (
    .audio_clk    (audio_clk),
    .rst_n        (rst_n),
    .sample       (sample),
    .sample_valid (sample_valid),
    .cfg          (cfg),
    .conv         (conv),
    .conv_valid   (conv_valid)
  );

  mix_pdm_out u_mix_pdm_out (
    .audio_clk  (audio_clk),
    .rst_n      (rst_n),
    .echo       (echo),
    .echo_valid (echo_valid),
    .conv       (conv),
    .conv_valid (conv_valid),
    .cfg        (cfg),
    .mix_last   (mix_last),
    .pdm_out    (pdm_out)
  );

  cfg_regs u_cfg_regs (
    .audio_clk (audio_clk),
    .rst_n     (rst_n),
    .apb_req   (apb_req),
    .mix_last  (mix_last),
    .apb_rsp   (apb_rsp),
    .cfg       (cfg)
  );

endmodule

/* cfg_regs.sv */
`timescale 1ns/1ps

module cfg_regs
  import audio_pkg::*;
  import regs_pkg::*;
(
  input  logic     audio_clk,
  input  logic     rst_n,
  input  apb_req_t apb_req,
  input  sample_t  mix_last,
  output apb_rsp_t apb_rsp,
  output cfg_t     cfg
);

  localparam int IDX_W = $clog2(NUM_TAPS);

  logic [7:0]       tap_off;
  logic [IDX_W-1:0] tap_idx;
  logic             tap_hit;
  logic             map_hit;
  logic             err;
  logic             access;
  logic             ready_q;

  assign access  = apb_req.psel && apb_req.penable;
  assign tap_off = apb_req.paddr - REG_TAP0;
  assign tap_idx = tap_off[IDX_W+1:2];
  assign tap_hit = (apb_req.paddr >= REG_TAP0) && (tap_off < 8'(NUM_TAPS * 4)) &&
                   (tap_off[1:0] == 2'b00);
  assign map_hit = tap_hit || (apb_req.paddr == REG_DELAY) ||
                   (apb_req.paddr == REG_GAINS) || (apb_req.paddr == REG_MIX);
  assign err     = !map_hit || (apb_req.pwrite && (apb_req.paddr == REG_MIX));

  always_comb begin
    case (apb_req.paddr)
      REG_DELAY: apb_rsp.prdata = 32'(cfg.echo_delay);
      REG_GAINS: apb_rsp.prdata = {16'h0, cfg.conv_gain, cfg.echo_gain};
      REG_MIX:   apb_rsp.prdata = {16'h0, mix_last};
      default:   apb_rsp.prdata = tap_hit ? {16'h0, cfg.taps[tap_idx]} : 32'h0;
    endcase
    apb_rsp.pready  = ready_q;
    apb_rsp.pslverr = access && err;
  end

  always_ff @(posedge audio_clk or negedge rst_n) begin
    if (!rst_n) begin
      cfg.echo_delay <= '0;
      cfg.echo_gain  <= 8'(GAIN_UNITY);  // echo only after reset
      cfg.conv_gain  <= '0;
      cfg.taps       <= '0;
      ready_q        <= 1'b0;
    end else begin
      ready_q <= 1'b1;  // no wait states
      if (access && apb_req.pwrite && !err) begin
        case (apb_req.paddr)
          REG_DELAY: cfg.echo_delay <= apb_req.pwdata[DELAY_W-1:0];
          REG_GAINS: begin
            cfg.echo_gain <= apb_req.pwdata[7:0];
            cfg.conv_gain <= apb_req.pwdata[15:8];
          end
          default:   cfg.taps[tap_idx] <= apb_req.pwdata[15:0];  // only taps left
        endcase
      end
    end
  end

  a_apb_phase: assert property (@(posedge audio_clk) disable iff (!rst_n)
    access |-> $past(apb_req.psel && !apb_req.penable));

endmodule

/* mix_pdm_out.sv */
`timescale 1ns/1ps

module mix_pdm_out
  import audio_pkg::*;
  import regs_pkg::*;
(
  input  logic    audio_clk,
  input  logic    rst_n,
  input  sample_t echo,
  input  logic    echo_valid,
  input  sample_t conv,
  input  logic    conv_valid,
  input  cfg_t    cfg,
  output sample_t mix_last,
  output logic    pdm_out
);

  sample_t     echo_q;
  sample_t     conv_q;
  logic        have_echo;
  logic        have_conv;
  logic        both;
  acc_t        echo_term;
  acc_t        conv_term;
  acc_t        mix_sum;
  logic [15:0] level;
  logic [15:0] pdm_acc;
  logic [16:0] pdm_sum;

  assign both = have_echo && have_conv;

  always_comb begin
    echo_term = echo_q * $signed({1'b0, cfg.echo_gain});  // gains are unsigned Q1.7
    conv_term = conv_q * $signed({1'b0, cfg.conv_gain});
    mix_sum   = echo_term + conv_term;
  end

  assign level   = {~mix_last[15], mix_last[14:0]};  // offset binary
  assign pdm_sum = {1'b0, pdm_acc} + {1'b0, level};

  always_ff @(posedge audio_clk) begin
    if (echo_valid) echo_q <= echo;
    if (conv_valid) conv_q <= conv;
  end

  always_ff @(posedge audio_clk or negedge rst_n) begin
    if (!rst_n) begin
      have_echo <= 1'b0;
      have_conv <= 1'b0;
      mix_last  <= '0;
      pdm_acc   <= '0;
      pdm_out   <= 1'b0;
    end else begin
      if (both) begin
        mix_last  <= sat16(mix_sum >>> 7);
        have_echo <= 1'b0;
        have_conv <= 1'b0;
      end
      // a new result wins over the clear
      if (echo_valid) have_echo <= 1'b1;
      if (conv_valid) have_conv <= 1'b1;
      // first order sigma-delta, carry is the bit
      pdm_acc <= pdm_sum[15:0];
      pdm_out <= pdm_sum[16];
    end
  end

endmodule

/* ir_convolver.sv */
`timescale 1ns/1ps

module ir_convolver
  import audio_pkg::*;
  import regs_pkg::*;
(
  input  logic    audio_clk,
  input  logic    rst_n,
  input  sample_t sample,
  input  logic    sample_valid,
  input  cfg_t    cfg,
  output sample_t conv,
  output logic    conv_valid
);

  localparam int IDX_W = $clog2(NUM_TAPS);

  sample_t            hist [NUM_TAPS];  // hist[k] is k frames back
  acc_t               acc;
  acc_t               acc_next;
  logic signed [31:0] prod;
  logic [IDX_W-1:0]   idx;
  logic               busy;
  logic               last;

  assign prod     = $signed(cfg.taps[idx]) * hist[idx];
  assign acc_next = acc + prod;
  assign last     = (idx == IDX_W'(NUM_TAPS - 1));

  // one tap per cycle, result lands NUM_TAPS+1 cycles after the sample
  always_ff @(posedge audio_clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int k = 0; k < NUM_TAPS; k++) begin
        hist[k] <= '0;
      end
      acc        <= '0;
      idx        <= '0;
      busy       <= 1'b0;
      conv       <= '0;
      conv_valid <= 1'b0;
    end else begin
      conv_valid <= 1'b0;
      if (sample_valid) begin
        hist[0] <= sample;
        for (int k = 1; k < NUM_TAPS; k++) begin
          hist[k] <= hist[k-1];
        end
        acc  <= '0;
        idx  <= '0;
        busy <= 1'b1;
      end else if (busy) begin
        acc <= acc_next;
        idx <= idx + 1'b1;
        if (last) begin
          busy       <= 1'b0;
          conv       <= sat16(acc_next >>> 15);  // back to Q1.15
          conv_valid <= 1'b1;
        end
      end
    end
  end

  // a new frame must not cut into a running sum
  a_no_overlap: assert property (@(posedge audio_clk) disable iff (!rst_n)
    sample_valid |-> !busy);

endmodule

/* echo_delay.sv */
`timescale 1ns/1ps

module echo_delay
  import audio_pkg::*;
  import regs_pkg::*;
(
  input  logic    audio_clk,
  input  logic    rst_n,
  input  sample_t sample,
  input  logic    sample_valid,
  input  cfg_t    cfg,
  output sample_t echo,
  output logic    echo_valid
);

  localparam int PTR_W = $clog2(ECHO_DEPTH);

  sample_t          ring [ECHO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;

  assign rd_ptr = wr_ptr - PTR_W'(cfg.echo_delay);  // wraps around the ring

  always_ff @(posedge audio_clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < ECHO_DEPTH; i++) begin
        ring[i] <= '0;
      end
      wr_ptr     <= '0;
      echo       <= '0;
      echo_valid <= 1'b0;
    end else begin
      echo_valid <= sample_valid;
      if (sample_valid) begin
        ring[wr_ptr] <= sample;
        wr_ptr       <= wr_ptr + 1'b1;
        // zero delay passes the new sample straight through
        echo <= (cfg.echo_delay == '0) ? sample : ring[rd_ptr];
      end
    end
  end

  a_echo_follows: assert property (@(posedge audio_clk) disable iff (!rst_n)
    sample_valid |=> echo_valid);

endmodule

/* i2s_rx.sv */
`timescale 1ns/1ps

module i2s_rx
  import audio_pkg::*;
(
  input  logic    audio_clk,
  input  logic    rst_n,
  input  logic    mic_data,
  output logic    bclk,
  output logic    lrcl,
  output sample_t sample,
  output logic    sample_valid
);

  localparam int DIV_W    = $clog2(BCLK_DIV);
  localparam int BIT_W    = $clog2(FRAME_CYCLES / (2 * BCLK_DIV));  // bclk periods per frame
  localparam int LAST_BIT = $bits(sample_t);                        // slot bit holding the lsb

  logic [DIV_W-1:0] div_cnt;
  logic [BIT_W-1:0] bit_cnt;
  logic [BIT_W-1:0] bit_nxt;
  logic [14:0]      shift_q;
  logic             half_done;
  logic             rise;
  logic             fall;
  logic             take_bit;
  logic             last_bit;

  assign half_done = (div_cnt == DIV_W'(BCLK_DIV - 1));
  assign rise      = half_done && !bclk;
  assign fall      = half_done && bclk;
  assign bit_nxt   = bit_cnt + 1'b1;
  // bit 0 is the one-bit delay, then msb first
  assign take_bit  = rise && (bit_cnt >= BIT_W'(1)) && (bit_cnt < BIT_W'(LAST_BIT));
  assign last_bit  = rise && (bit_cnt == BIT_W'(LAST_BIT));

  always_ff @(posedge audio_clk or negedge rst_n) begin
    if (!rst_n) begin
      div_cnt      <= '0;
      bit_cnt      <= '0;
      bclk         <= 1'b0;
      lrcl         <= 1'b0;
      sample_valid <= 1'b0;
    end else begin
      div_cnt      <= half_done ? '0 : div_cnt + 1'b1;
      sample_valid <= last_bit;
      if (half_done) bclk <= ~bclk;
      if (fall) begin
        bit_cnt <= bit_nxt;
        lrcl    <= (bit_nxt >= BIT_W'(SLOT_BITS));  // high for the right slot
      end
    end
  end

  always_ff @(posedge audio_clk) begin
    if (take_bit) shift_q <= {shift_q[13:0], mic_data};
    if (last_bit) sample <= {shift_q, mic_data};
  end

  a_valid_single: assert property (@(posedge audio_clk) disable iff (!rst_n)
    sample_valid |=> !sample_valid);

endmodule

/* regs_pkg.sv */
package regs_pkg;

  import audio_pkg::*;

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  // live settings for the datapath
  typedef struct packed {
    logic [DELAY_W-1:0]          echo_delay;  // in samples
    logic [7:0]                  echo_gain;
    logic [7:0]                  conv_gain;
    sample_t [NUM_TAPS-1:0]      taps;        // Q1.15
  } cfg_t;

  // register map
  localparam logic [7:0] REG_DELAY = 8'h00;
  localparam logic [7:0] REG_GAINS = 8'h04;   // [7:0] echo, [15:8] conv
  localparam logic [7:0] REG_MIX   = 8'h08;   // read only
  localparam logic [7:0] REG_TAP0  = 8'h10;   // taps at 4 byte steps

endpackage

/* audio_pkg.sv */
package audio_pkg;

  typedef logic signed [15:0] sample_t;
  typedef logic signed [39:0] acc_t;   // convolver and mixer sums

  // i2s timing
  localparam int BCLK_DIV     = 2;     // audio_clk cycles per bclk half period
  localparam int SLOT_BITS    = 32;    // bclk periods per channel slot
  localparam int FRAME_CYCLES = 2 * BCLK_DIV * SLOT_BITS * 2;

  // datapath sizes
  localparam int NUM_TAPS   = 8;
  localparam int ECHO_DEPTH = 64;
  localparam int DELAY_W    = 6;
  localparam int GAIN_UNITY = 128;     // gain of 1.0, Q1.7

  localparam acc_t SAT_HI = 40'sd32767;
  localparam acc_t SAT_LO = -40'sd32768;

  // clamp a wide sum into the sample range
  function automatic sample_t sat16(input acc_t v);
    if (v > SAT_HI) begin
      return 16'sh7fff;
    end else if (v < SAT_LO) begin
      return 16'sh8000;
    end
    return v[15:0];
  endfunction

endpackage
